// ==== sources.f ====
vlane_pkg.sv
lane_ctrl_if.sv
addr_counter.sv
lane_sequencer.sv
lane_bwen_unit.sv
vrf_write_port.sv
vlane_ctrl_top.sv
tb_vlane_ctrl.sv

// ==== tb_vlane_ctrl.sv ====
`timescale 1ns/1ns

module tb_vlane_ctrl;

   localparam int VLANE_NUM       = 8;
   localparam int MEM_DEPTH       = 512;
   localparam int MAX_VL_PER_LANE = 256;
   localparam int AW      = $clog2(MEM_DEPTH);
   localparam int VL_W    = $clog2(VLANE_NUM * MAX_VL_PER_LANE + 1);
   localparam int DLY_W   = $clog2(MAX_VL_PER_LANE);
   localparam int BPW     = vlane_pkg::BYTES_PER_WORD;
   localparam int TIMEOUT = 2000;  // cycles per wait

   logic                          clk;
   logic                          rstn;
   logic                          start;
   vlane_pkg::inst_type_e         inst_type;
   vlane_pkg::sew_e               vsew;
   logic [VL_W-1:0]               vl;
   logic [DLY_W-1:0]              inst_delay;
   logic [AW-1:0]                 start_raddr;
   logic [AW-1:0]                 start_waddr;
   logic                          ready;
   logic                          vrf_ren;
   logic [AW-1:0]                 vrf_raddr;
   logic                          store_valid;
   logic                          ready_for_load;
   logic                          load_valid;
   logic                          load_last;
   logic [VLANE_NUM-1:0][BPW-1:0] load_bwen;
   logic [VLANE_NUM-1:0][AW-1:0]  vrf_waddr;
   logic [VLANE_NUM-1:0][BPW-1:0] vrf_bwen;

   logic [31:0]   lfsr_q = 32'hbf8e_200d;
   int            cyc = 0;
   int            err_cnt = 0;
   int            tests_run = 0;
   int            tests_failed = 0;
   // write records are {lane, word address, byte enables}
   logic [16:0]   wr_q[$];
   logic [16:0]   exp_q[$];
   logic [AW-1:0] rd_q[$];
   logic [AW-1:0] exp_rd_q[$];
   int            first_rd_cyc;
   int            first_wr_cyc;
   int            sdv_cnt;
   int            sdv_rd_cnt;  // store valid together with read enable

   vlane_ctrl_top #(
      .VLANE_NUM       (VLANE_NUM),
      .MEM_DEPTH       (MEM_DEPTH),
      .MAX_VL_PER_LANE (MAX_VL_PER_LANE)
   ) dut (
      .clk_i              (clk),
      .rstn_i             (rstn),
      .start_i            (start),
      .inst_type_i        (inst_type),
      .vsew_i             (vsew),
      .vl_i               (vl),
      .inst_delay_i       (inst_delay),
      .vrf_start_raddr_i  (start_raddr),
      .vrf_start_waddr_i  (start_waddr),
      .ready_o            (ready),
      .vrf_ren_o          (vrf_ren),
      .vrf_raddr_o        (vrf_raddr),
      .store_data_valid_o (store_valid),
      .ready_for_load_o   (ready_for_load),
      .load_valid_i       (load_valid),
      .load_last_i        (load_last),
      .load_bwen_i        (load_bwen),
      .vrf_waddr_o        (vrf_waddr),
      .vrf_bwen_o         (vrf_bwen)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk) cyc <= cyc + 1;

   ////////////////////////////////////////
   // monitor sampled mid-cycle
   ////////////////////////////////////////

   always @(negedge clk) begin
      if (rstn) begin
         if (vrf_ren) begin
            if (rd_q.size() == 0) first_rd_cyc = cyc;
            rd_q.push_back(vrf_raddr);
         end
         if (store_valid) sdv_cnt++;
         if (store_valid && vrf_ren) sdv_rd_cnt++;
         for (int i = 0; i < VLANE_NUM; i++) begin
            if (vrf_bwen[i] != '0) begin
               if (wr_q.size() == 0) first_wr_cyc = cyc;
               wr_q.push_back({4'(i), vrf_waddr[i], vrf_bwen[i]});
            end
         end
      end
   end

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic lfsr_bit();
      logic fb;
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      return fb;
   endfunction

   function automatic int unsigned rand_bits(input int w);
      int unsigned v;
      v = 0;
      for (int b = 0; b < w; b++) v = (v << 1) | lfsr_bit();
      return v;
   endfunction

   // byte lanes of element k inside its word
   function automatic logic [BPW-1:0] exp_bwen(input vlane_pkg::sew_e sew, input int k);
      case (sew)
         vlane_pkg::SEW_BYTE: return 4'b0001 << (k % 4);
         vlane_pkg::SEW_HALF: return 4'b0011 << (2 * (k % 2));
         default:             return 4'b1111;
      endcase
   endfunction

   task automatic step();
      @(posedge clk);
      #2;
   endtask

   task automatic report_error(input string msg);
      $display("** Error @ %0t ns: %s", $time, msg);
      err_cnt++;
   endtask

   task automatic test_done(input string name, input int err0);
      tests_run++;
      if (err_cnt != err0) begin
         tests_failed++;
         $display("test %s failed with %0d errors", name, err_cnt - err0);
      end else begin
         $display("test %s ok", name);
      end
   endtask

   task automatic clear_monitor();
      wr_q.delete();
      exp_q.delete();
      rd_q.delete();
      exp_rd_q.delete();
      sdv_cnt    = 0;
      sdv_rd_cnt = 0;
   endtask

   task automatic issue(input vlane_pkg::inst_type_e it, input vlane_pkg::sew_e sew,
                        input int vl_v, input int dly, input int ra, input int wa);
      if (!ready) report_error("ready_o low before a new instruction");
      start       = 1'b1;
      inst_type   = it;
      vsew        = sew;
      vl          = VL_W'(vl_v);
      inst_delay  = DLY_W'(dly);
      start_raddr = AW'(ra);
      start_waddr = AW'(wa);
      step();
      start = 1'b0;
   endtask

   // busy pulses start_i with junk fields while the DUT runs
   task automatic wait_ready(input bit busy, input string what);
      int t;
      t = 0;
      while (!ready && t < TIMEOUT) begin
         if (busy) begin
            start       = (t % 2 == 0);
            inst_type   = vlane_pkg::inst_type_e'(2 * rand_bits(1));
            vsew        = vlane_pkg::sew_e'(rand_bits(1));
            vl          = VL_W'(rand_bits(8));
            start_raddr = AW'(rand_bits(AW));
            start_waddr = AW'(rand_bits(AW));
         end
         step();
         t++;
      end
      start = 1'b0;
      if (!ready) begin
         $display("timeout: %s did not happen within %0d cycles", what, TIMEOUT);
         err_cnt++;
      end
   endtask

   task automatic compare_writes();
      if (wr_q.size() != exp_q.size()) begin
         report_error($sformatf("%0d byte-enable writes seen, expected %0d",
                                wr_q.size(), exp_q.size()));
      end else begin
         for (int j = 0; j < wr_q.size(); j++) begin
            if (wr_q[j] != exp_q[j]) begin
               report_error($sformatf("write %0d lane %0d addr %0h bwen %b, expected %0d %0h %b",
                  j, wr_q[j][16:13], wr_q[j][12:4], wr_q[j][3:0],
                  exp_q[j][16:13], exp_q[j][12:4], exp_q[j][3:0]));
            end
         end
      end
   endtask

   task automatic compare_reads();
      if (rd_q.size() != exp_rd_q.size()) begin
         report_error($sformatf("vrf_ren_o high %0d cycles, expected %0d",
                                rd_q.size(), exp_rd_q.size()));
      end else begin
         for (int j = 0; j < rd_q.size(); j++) begin
            if (rd_q[j] != exp_rd_q[j]) begin
               report_error($sformatf("read %0d addr %0h, expected %0h",
                                      j, rd_q[j], exp_rd_q[j]));
            end
         end
      end
   endtask

   ////////////////////////////////////////
   // reference model and runs
   ////////////////////////////////////////

   task automatic build_model(input vlane_pkg::sew_e sew, input int vl_v, input int ra,
                              input int wa, input bit writes);
      int n;
      int e;
      int k;
      int i;
      n = (vl_v + VLANE_NUM - 1) / VLANE_NUM;
      e = (sew == vlane_pkg::SEW_BYTE) ? 4 : (sew == vlane_pkg::SEW_HALF) ? 2 : 1;
      for (k = 0; k < n; k++) begin
         exp_rd_q.push_back(AW'((ra + k / e) % MEM_DEPTH));
         for (i = 0; i < VLANE_NUM && writes; i++) begin
            if (k * VLANE_NUM + i < vl_v) begin  // tail lanes skipped
               exp_q.push_back({4'(i), AW'((wa + k / e) % MEM_DEPTH), exp_bwen(sew, k)});
            end
         end
      end
   endtask

   task automatic run_normal(input vlane_pkg::sew_e sew, input int vl_v, input int dly,
                             input bit busy);
      int ra;
      int wa;
      ra = rand_bits(AW);
      wa = rand_bits(AW);
      clear_monitor();
      build_model(sew, vl_v, ra, wa, 1'b1);
      issue(vlane_pkg::INST_NORMAL, sew, vl_v, dly, ra, wa);
      wait_ready(busy, "ready_o after a normal instruction");
      step();
      compare_writes();
      compare_reads();
      if (sdv_cnt != 0) report_error("store_data_valid_o high during a normal instruction");
      if (wr_q.size() != 0 && rd_q.size() != 0 && first_wr_cyc - first_rd_cyc != dly + 2) begin
         report_error($sformatf("first write %0d cycles after first read, expected %0d",
                                first_wr_cyc - first_rd_cyc, dly + 2));
      end
   endtask

   task automatic test_reset();
      int err0;
      err0 = err_cnt;
      if (ready !== 1'b1) report_error("ready_o not high after reset");
      if (vrf_ren !== 1'b0) report_error("vrf_ren_o not low after reset");
      if (store_valid !== 1'b0) report_error("store_data_valid_o not low after reset");
      if (ready_for_load !== 1'b0) report_error("ready_for_load_o not low after reset");
      if (vrf_bwen !== '0) report_error("vrf_bwen_o not zero after reset");
      test_done("reset", err0);
   endtask

   task automatic test_full();
      int err0;
      err0 = err_cnt;
      run_normal(vlane_pkg::SEW_BYTE, VLANE_NUM * (1 + rand_bits(5)), rand_bits(3), 1'b0);
      run_normal(vlane_pkg::SEW_HALF, VLANE_NUM * (1 + rand_bits(5)), rand_bits(3), 1'b0);
      run_normal(vlane_pkg::SEW_WORD, VLANE_NUM * (1 + rand_bits(5)), rand_bits(3), 1'b0);
      test_done("full", err0);
   endtask

   task automatic test_tail();
      int err0;
      err0 = err_cnt;
      repeat (4) begin
         run_normal(vlane_pkg::sew_e'(rand_bits(2) % 3), 1 + rand_bits(8), rand_bits(4), 1'b0);
      end
      test_done("tail", err0);
   endtask

   task automatic test_store();
      int err0;
      int n;
      int vl_v;
      int ra;
      vlane_pkg::sew_e sew;
      err0 = err_cnt;
      repeat (2) begin
         vl_v = 1 + rand_bits(7);
         ra   = rand_bits(AW);
         sew  = vlane_pkg::sew_e'(rand_bits(2) % 3);
         n    = (vl_v + VLANE_NUM - 1) / VLANE_NUM;
         clear_monitor();
         build_model(sew, vl_v, ra, 0, 1'b0);
         issue(vlane_pkg::INST_STORE, sew, vl_v, rand_bits(3), ra, rand_bits(AW));
         wait_ready(1'b0, "ready_o after a store");
         step();
         compare_reads();
         compare_writes();  // a store writes nothing
         if (sdv_cnt != n || sdv_rd_cnt != n) begin
            report_error($sformatf("store valid %0d cycles, %0d with read, expected %0d",
                                   sdv_cnt, sdv_rd_cnt, n));
         end
      end
      test_done("store", err0);
   endtask

   task automatic test_load();
      int err0;
      int wa;
      int beats;
      int j;
      int i;
      int t;
      err0 = err_cnt;
      repeat (2) begin
         wa    = rand_bits(AW);
         beats = 1 + rand_bits(4);
         clear_monitor();
         issue(vlane_pkg::INST_LOAD, vlane_pkg::SEW_BYTE, 0, 0, 0, wa);
         t = 0;
         while (!ready_for_load && t < TIMEOUT) begin
            step();
            t++;
         end
         if (!ready_for_load) begin
            $display("timeout: ready_for_load_o did not rise within %0d cycles", TIMEOUT);
            err_cnt++;
         end
         for (j = 0; j < beats; j++) begin
            repeat (rand_bits(2)) step();  // gap with nothing written
            load_valid = 1'b1;
            load_last  = (j == beats - 1);
            load_bwen  = rand_bits(32);
            for (i = 0; i < VLANE_NUM; i++) begin
               if (load_bwen[i] != '0) begin
                  exp_q.push_back({4'(i), AW'((wa + j) % MEM_DEPTH), load_bwen[i]});
               end
            end
            if (load_last && !ready_for_load) report_error("ready_for_load_o low at last beat");
            step();
            load_valid = 1'b0;
            load_last  = 1'b0;
            load_bwen  = '0;
         end
         if (ready_for_load) report_error("ready_for_load_o still high after load_last_i");
         if (!ready) report_error("ready_o not back after load_last_i");
         step();
         step();
         compare_writes();
         if (rd_q.size() != 0) report_error("vrf_ren_o high during a load");
      end
      test_done("load", err0);
   endtask

   task automatic test_busy();
      int err0;
      err0 = err_cnt;
      run_normal(vlane_pkg::SEW_HALF, 5 + rand_bits(6), rand_bits(3), 1'b1);
      test_done("busy", err0);
   endtask

   initial begin
      rstn        = 1'b0;
      start       = 1'b0;
      inst_type   = vlane_pkg::INST_NORMAL;
      vsew        = vlane_pkg::SEW_BYTE;
      vl          = '0;
      inst_delay  = '0;
      start_raddr = '0;
      start_waddr = '0;
      load_valid  = 1'b0;
      load_last   = 1'b0;
      load_bwen   = '0;
      repeat (8) step();
      rstn = 1'b1;
      test_reset();
      test_full();
      test_tail();
      test_store();
      test_load();
      test_busy();
      $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
      if (err_cnt == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

// ==== vlane_ctrl_top.sv ====
`timescale 1ns/1ns

module vlane_ctrl_top #(
   parameter int VLANE_NUM       = 8,
   parameter int MEM_DEPTH       = 512,
   parameter int MAX_VL_PER_LANE = 256
) (
   input  logic                                                clk_i,
   input  logic                                                rstn_i,
   // instruction
   input  logic                                                start_i,
   input  vlane_pkg::inst_type_e                               inst_type_i,
   input  vlane_pkg::sew_e                                     vsew_i,
   input  logic [$clog2(VLANE_NUM*MAX_VL_PER_LANE+1)-1:0]      vl_i,
   input  logic [$clog2(MAX_VL_PER_LANE)-1:0]                  inst_delay_i,
   input  logic [$clog2(MEM_DEPTH)-1:0]                        vrf_start_raddr_i,
   input  logic [$clog2(MEM_DEPTH)-1:0]                        vrf_start_waddr_i,
   // read side
   output logic                                                ready_o,
   output logic                                                vrf_ren_o,
   output logic [$clog2(MEM_DEPTH)-1:0]                        vrf_raddr_o,
   output logic                                                store_data_valid_o,
   // load side
   output logic                                                ready_for_load_o,
   input  logic                                                load_valid_i,
   input  logic                                                load_last_i,
   input  logic [VLANE_NUM-1:0][vlane_pkg::BYTES_PER_WORD-1:0] load_bwen_i,
   // write side, one per lane
   output logic [VLANE_NUM-1:0][$clog2(MEM_DEPTH)-1:0]         vrf_waddr_o,
   output logic [VLANE_NUM-1:0][vlane_pkg::BYTES_PER_WORD-1:0] vrf_bwen_o
);

   logic [VLANE_NUM-1:0][vlane_pkg::BYTES_PER_WORD-1:0] lane_bwen;
   vlane_pkg::seq_state_e                               load_mode;
   logic                                                load_wr;

   lane_ctrl_if #(
      .VLANE_NUM       (VLANE_NUM),
      .MAX_VL_PER_LANE (MAX_VL_PER_LANE)
   ) ctrl_if ();

   lane_sequencer #(
      .VLANE_NUM       (VLANE_NUM),
      .MEM_DEPTH       (MEM_DEPTH),
      .MAX_VL_PER_LANE (MAX_VL_PER_LANE)
   ) u_seq (
      .clk_i              (clk_i),
      .rstn_i             (rstn_i),
      .start_i            (start_i),
      .inst_type_i        (inst_type_i),
      .vsew_i             (vsew_i),
      .vl_i               (vl_i),
      .inst_delay_i       (inst_delay_i),
      .vrf_start_raddr_i  (vrf_start_raddr_i),
      .ready_o            (ready_o),
      .vrf_ren_o          (vrf_ren_o),
      .vrf_raddr_o        (vrf_raddr_o),
      .store_data_valid_o (store_data_valid_o),
      .ready_for_load_o   (ready_for_load_o),
      .load_valid_i       (load_valid_i),
      .load_last_i        (load_last_i),
      .load_mode_o        (load_mode),
      .load_wr_o          (load_wr),
      .ctrl               (ctrl_if.seq)
   );

   ////////////////////////////////////////
   // per-lane byte enables
   ////////////////////////////////////////

   for (genvar i = 0; i < VLANE_NUM; i++) begin : g_lane
      lane_bwen_unit #(
         .LANE_IDX        (i),
         .VLANE_NUM       (VLANE_NUM),
         .MAX_VL_PER_LANE (MAX_VL_PER_LANE)
      ) u_bwen (
         .clk_i  (clk_i),
         .rstn_i (rstn_i),
         .ctrl   (ctrl_if.lane),
         .bwen_o (lane_bwen[i])
      );
   end

   vrf_write_port #(
      .VLANE_NUM (VLANE_NUM),
      .MEM_DEPTH (MEM_DEPTH)
   ) u_wport (
      .clk_i             (clk_i),
      .rstn_i            (rstn_i),
      .vrf_start_waddr_i (vrf_start_waddr_i),
      .start_i           (start_i),
      .ctrl              (ctrl_if.drain),
      .lane_bwen_i       (lane_bwen),
      .load_mode_i       (load_mode),
      .load_wr_i         (load_wr),
      .load_bwen_i       (load_bwen_i),
      .vrf_bwen_o        (vrf_bwen_o),
      .vrf_waddr_o       (vrf_waddr_o)
   );

endmodule

// ==== vrf_write_port.sv ====
`timescale 1ns/1ns

module vrf_write_port #(
   parameter int VLANE_NUM = 8,
   parameter int MEM_DEPTH = 512
) (
   input  logic                                                clk_i,
   input  logic                                                rstn_i,
   input  logic [$clog2(MEM_DEPTH)-1:0]                        vrf_start_waddr_i,
   input  logic                                                start_i,
   lane_ctrl_if.drain                                          ctrl,
   input  logic [VLANE_NUM-1:0][vlane_pkg::BYTES_PER_WORD-1:0] lane_bwen_i,
   input  vlane_pkg::seq_state_e                               load_mode_i,
   input  logic                                                load_wr_i,
   input  logic [VLANE_NUM-1:0][vlane_pkg::BYTES_PER_WORD-1:0] load_bwen_i,
   output logic [VLANE_NUM-1:0][vlane_pkg::BYTES_PER_WORD-1:0] vrf_bwen_o,
   output logic [VLANE_NUM-1:0][$clog2(MEM_DEPTH)-1:0]         vrf_waddr_o
);

   localparam int AW = $clog2(MEM_DEPTH);

   logic          load_sel;
   logic          waddr_load;
   logic [AW-1:0] waddr_cnt;
   logic [AW-1:0] waddr_d;  // matches the lane bwen register
   logic [AW-1:0] waddr_q;

   assign load_sel   = (load_mode_i == vlane_pkg::ST_LOAD);
   assign waddr_load = start_i && (load_mode_i == vlane_pkg::ST_IDLE);  // accepted starts only

   addr_counter #(
      .MEM_DEPTH (MEM_DEPTH)
   ) u_waddr_cnt (
      .clk_i        (clk_i),
      .rstn_i       (rstn_i),
      .start_addr_i (vrf_start_waddr_i),
      .load_i       (waddr_load),
      .sew_i        (ctrl.sew),
      .en_i         (ctrl.wr_active || load_wr_i),
      .addr_o       (waddr_cnt)
   );

   ////////////////////////////////////////
   // output stage
   ////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      waddr_d <= waddr_cnt;
      waddr_q <= load_sel ? waddr_cnt : waddr_d;  // load beats skip the lane stage
   end

   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         vrf_bwen_o <= '0;
      end else if (load_sel) begin
         vrf_bwen_o <= load_wr_i ? load_bwen_i : '0;  // gaps write nothing
      end else begin
         vrf_bwen_o <= lane_bwen_i;
      end
   end

   // all lanes write the same word
   assign vrf_waddr_o = {VLANE_NUM{waddr_q}};

endmodule

// ==== lane_bwen_unit.sv ====
`timescale 1ns/1ns

module lane_bwen_unit #(
   parameter int LANE_IDX        = 0,
   parameter int VLANE_NUM       = 8,
   parameter int MAX_VL_PER_LANE = 256
) (
   input  logic                                clk_i,
   input  logic                                rstn_i,
   lane_ctrl_if.lane                           ctrl,
   output logic [vlane_pkg::BYTES_PER_WORD-1:0] bwen_o
);

   localparam int BPW  = vlane_pkg::BYTES_PER_WORD;
   localparam int SW   = vlane_pkg::BYTE_SEL_W;
   localparam int VL_W = $clog2(VLANE_NUM * MAX_VL_PER_LANE + 1);

   logic [VL_W-1:0] elem_pos;  // element position in the whole vector
   logic            in_vl;
   logic [BPW-1:0]  pattern;

   // elements are striped, lane i holds k*VLANE_NUM + i
   assign elem_pos = VL_W'(ctrl.elem_idx) * VL_W'(VLANE_NUM) + VL_W'(LANE_IDX);
   assign in_vl    = (elem_pos < ctrl.vl);  // tail lanes stay quiet

   ////////////////////////////////////////
   // byte pattern per width
   ////////////////////////////////////////

   always_comb begin
      case (ctrl.sew)
         vlane_pkg::SEW_BYTE: pattern = BPW'(1) << ctrl.elem_idx[SW-1:0];
         vlane_pkg::SEW_HALF: pattern = BPW'(3) << {ctrl.elem_idx[0], 1'b0};  // low or high pair
         vlane_pkg::SEW_WORD: pattern = '1;
         default:             pattern = '0;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         bwen_o <= '0;
      end else begin
         bwen_o <= (ctrl.wr_active && in_vl) ? pattern : '0;
      end
   end

endmodule

// ==== lane_sequencer.sv ====
`timescale 1ns/1ns

module lane_sequencer #(
   parameter int VLANE_NUM       = 8,
   parameter int MEM_DEPTH       = 512,
   parameter int MAX_VL_PER_LANE = 256
) (
   input  logic                                           clk_i,
   input  logic                                           rstn_i,
   input  logic                                           start_i,
   input  vlane_pkg::inst_type_e                          inst_type_i,
   input  vlane_pkg::sew_e                                vsew_i,
   input  logic [$clog2(VLANE_NUM*MAX_VL_PER_LANE+1)-1:0] vl_i,
   input  logic [$clog2(MAX_VL_PER_LANE)-1:0]             inst_delay_i,
   input  logic [$clog2(MEM_DEPTH)-1:0]                   vrf_start_raddr_i,
   output logic                                           ready_o,
   output logic                                           vrf_ren_o,
   output logic [$clog2(MEM_DEPTH)-1:0]                   vrf_raddr_o,
   output logic                                           store_data_valid_o,
   output logic                                           ready_for_load_o,
   input  logic                                           load_valid_i,
   input  logic                                           load_last_i,
   output vlane_pkg::seq_state_e                          load_mode_o,
   output logic                                           load_wr_o,
   lane_ctrl_if.seq                                       ctrl
);

   localparam int IDX_W   = $clog2(MAX_VL_PER_LANE);
   localparam int VL_W    = $clog2(VLANE_NUM * MAX_VL_PER_LANE + 1);
   localparam int CNT_W   = IDX_W + 2;  // n + delay + two write stages
   localparam int LANE_SH = $clog2(VLANE_NUM);

   vlane_pkg::seq_state_e state_q, state_d;
   vlane_pkg::inst_type_e inst_q;
   vlane_pkg::sew_e       sew_q;
   logic [VL_W-1:0]       vl_q;
   logic [IDX_W-1:0]      delay_q;
   logic [IDX_W:0]        n_q;       // elements per lane
   logic [VL_W-1:0]       vl_round;
   logic [CNT_W-1:0]      cnt_q;     // shared by read and delayed write
   logic [CNT_W-1:0]      last_cnt;
   logic [CNT_W-1:0]      wr_off;
   logic                  accept;
   logic                  rd_active;

   assign accept   = start_i && (state_q == vlane_pkg::ST_IDLE);
   assign vl_round = vl_i + VL_W'(VLANE_NUM - 1);  // n rounds up

   ////////////////////////////////////////
   // instruction FSM
   ////////////////////////////////////////

   // store ends on its last read, normal once the last write leaves the write port
   assign last_cnt = (inst_q == vlane_pkg::INST_STORE) ?
                     CNT_W'(n_q) - CNT_W'(1) :
                     CNT_W'(n_q) + CNT_W'(delay_q) + CNT_W'(1);

   always_comb begin
      state_d = state_q;
      case (state_q)
         vlane_pkg::ST_IDLE: begin
            if (start_i) begin
               state_d = (inst_type_i == vlane_pkg::INST_LOAD) ? vlane_pkg::ST_LOAD :
                                                                 vlane_pkg::ST_RUN;
            end
         end
         vlane_pkg::ST_RUN: begin
            if (cnt_q == last_cnt) begin
               state_d = vlane_pkg::ST_IDLE;
            end
         end
         vlane_pkg::ST_LOAD: begin
            if (load_last_i) begin
               state_d = vlane_pkg::ST_IDLE;
            end
         end
         default: state_d = vlane_pkg::ST_IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         state_q <= vlane_pkg::ST_IDLE;
         cnt_q   <= '0;
      end else begin
         state_q <= state_d;
         cnt_q   <= (state_q == vlane_pkg::ST_RUN) ? cnt_q + CNT_W'(1) : '0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept) begin
         inst_q  <= inst_type_i;
         sew_q   <= (inst_type_i == vlane_pkg::INST_LOAD) ? vlane_pkg::SEW_WORD : vsew_i;
         vl_q    <= vl_i;
         delay_q <= inst_delay_i;
         n_q     <= vl_round[VL_W-1:LANE_SH];
      end
   end

   ////////////////////////////////////////
   // read side
   ////////////////////////////////////////

   assign rd_active = (state_q == vlane_pkg::ST_RUN) && (cnt_q < CNT_W'(n_q));

   addr_counter #(
      .MEM_DEPTH (MEM_DEPTH)
   ) u_raddr_cnt (
      .clk_i        (clk_i),
      .rstn_i       (rstn_i),
      .start_addr_i (vrf_start_raddr_i),
      .load_i       (accept),
      .sew_i        (sew_q),
      .en_i         (rd_active),
      .addr_o       (vrf_raddr_o)
   );

   assign ready_o            = (state_q == vlane_pkg::ST_IDLE);
   assign vrf_ren_o          = rd_active;
   assign store_data_valid_o = rd_active && (inst_q == vlane_pkg::INST_STORE);
   assign ready_for_load_o   = (state_q == vlane_pkg::ST_LOAD);
   assign load_wr_o          = ready_for_load_o && load_valid_i;  // one load beat
   assign load_mode_o        = state_q;

   // write phase, inst_delay after the first read
   assign wr_off         = cnt_q - CNT_W'(delay_q);
   assign ctrl.wr_active = (state_q == vlane_pkg::ST_RUN) && (inst_q == vlane_pkg::INST_NORMAL)
                           && (cnt_q >= CNT_W'(delay_q)) && (wr_off < CNT_W'(n_q));
   assign ctrl.elem_idx  = wr_off[IDX_W-1:0];
   assign ctrl.sew       = sew_q;
   assign ctrl.vl        = vl_q;

endmodule

// ==== addr_counter.sv ====
`timescale 1ns/1ns

module addr_counter #(
   parameter int MEM_DEPTH = 512
) (
   input  logic                         clk_i,
   input  logic                         rstn_i,
   input  logic [$clog2(MEM_DEPTH)-1:0] start_addr_i,
   input  logic                         load_i,
   input  vlane_pkg::sew_e              sew_i,
   input  logic                         en_i,
   output logic [$clog2(MEM_DEPTH)-1:0] addr_o
);

   localparam int SW  = vlane_pkg::BYTE_SEL_W;
   localparam int BPW = vlane_pkg::BYTES_PER_WORD;

   logic [SW-1:0] elem_cnt_q;  // elements already taken from the current word
   logic          word_done;

   // last element of the word at the current width
   always_comb begin
      case (sew_i)
         vlane_pkg::SEW_BYTE: word_done = (elem_cnt_q == SW'(BPW - 1));
         vlane_pkg::SEW_HALF: word_done = (elem_cnt_q == SW'(BPW / 2 - 1));
         default:             word_done = 1'b1;  // one word per element
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         elem_cnt_q <= '0;
      end else if (load_i) begin
         elem_cnt_q <= '0;
      end else if (en_i) begin
         elem_cnt_q <= word_done ? '0 : elem_cnt_q + SW'(1);
      end
   end

   always_ff @(posedge clk_i) begin
      if (load_i) begin
         addr_o <= start_addr_i;
      end else if (en_i && word_done) begin
         addr_o <= addr_o + 1'b1;  // next word
      end
   end

endmodule

// ==== lane_ctrl_if.sv ====
`timescale 1ns/1ns

interface lane_ctrl_if #(
   parameter int VLANE_NUM       = 8,
   parameter int MAX_VL_PER_LANE = 256
) ();

   localparam int IDX_W = $clog2(MAX_VL_PER_LANE);
   localparam int VL_W  = $clog2(VLANE_NUM * MAX_VL_PER_LANE + 1);

   logic             wr_active;  // every lane handles one element this cycle
   logic [IDX_W-1:0] elem_idx;   // element index inside a lane
   vlane_pkg::sew_e  sew;
   logic [VL_W-1:0]  vl;

   modport seq (output wr_active, output elem_idx, output sew, output vl);

   modport lane (input wr_active, input elem_idx, input sew, input vl);

   // write side only needs to know when the word address steps
   modport drain (input wr_active, input sew);

endinterface

// ==== vlane_pkg.sv ====
package vlane_pkg;

   ////////////////////////////////////////
   // register file word layout
   ////////////////////////////////////////

   localparam int BYTES_PER_WORD = 4;
   localparam int BYTE_SEL_W     = $clog2(BYTES_PER_WORD);  // byte index inside a word

   ////////////////////////////////////////
   // instruction and width codes
   ////////////////////////////////////////

   typedef enum logic [1:0] {
      INST_NORMAL = 2'd0,  // read, then write back
      INST_STORE  = 2'd1,  // read only
      INST_LOAD   = 2'd2   // write only, data comes from the load unit
   } inst_type_e;

   // element width
   typedef enum logic [1:0] {
      SEW_BYTE = 2'd0,
      SEW_HALF = 2'd1,
      SEW_WORD = 2'd2
   } sew_e;

   ////////////////////////////////////////
   // sequencer states
   ////////////////////////////////////////

   typedef enum logic [1:0] {
      ST_IDLE = 2'd0,
      ST_RUN  = 2'd1,  // reads, delay, then lane writes
      ST_LOAD = 2'd2   // waiting on load beats
   } seq_state_e;

endpackage
